/* Makefile */
TOP = tb_mcfifo

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f compile.f --top-module mcfifo_top
	verilator --lint-only --timing -f compile.f --top-module $(TOP)

sim:
	verilator --binary --timing -f compile.f --top-module $(TOP) -o $(TOP)
	@out=$$(./obj_dir/$(TOP)); echo "$$out"; \
	echo "$$out" | grep -q "Verification passed"

clean:
	rm -rf obj_dir

/* bench/tb_mcfifo.sv */
`timescale 1ns/100ps
`default_nettype none
`include "mcfifo_defs.svh"

module tb_mcfifo
    import mcfifo_pkg::*;
;

    localparam int NUM_CH         = `MCFIFO_NUM_CHANNELS;
    localparam int PKT_WORDS      = `MCFIFO_PACKET_WORDS;
    localparam int TIMEOUT_CYCLES = 3000;   // Tests need about 600

    logic         clk;
    logic         reset;
    logic         wr_n;
    bus_word_t    bus_in;
    bus_word_t    bus_out;
    logic [3:0]   lane_oe;
    logic         be_oe;
    logic         txe_n;
    logic         rxf_n;
    sink_report_t sink_report [NUM_CH:1];

    int           seed;
    int           cycles = 0;
    logic [23:0]  next_seq [NUM_CH:1];      // Next to-host sequence per channel
    sink_report_t exp_report [NUM_CH:1];    // Expected sink totals

    mcfifo_top i_mcfifo_top (
        .clk         (clk),
        .reset       (reset),
        .wr_n        (wr_n),
        .bus_in      (bus_in),
        .bus_out     (bus_out),
        .lane_oe     (lane_oe),
        .be_oe       (be_oe),
        .txe_n       (txe_n),
        .rxf_n       (rxf_n),
        .sink_report (sink_report)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            fail_run("Timeout: the tests did not finish within the cycle limit");
        end
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic check_value(input string test, input logic [63:0] expected,
                               input logic [63:0] actual);
        assert (actual === expected) else
            fail_run($sformatf("ERROR %s: expected 0x%0h, actual 0x%0h",
                               test, expected, actual));
    endtask

    function automatic logic [31:0] masked_byte_sum(input bus_word_t w);
        logic [31:0] sum;
        sum = '0;
        for (int i = 0; i < 4; i++) begin
            if (w.be[i]) begin
                sum = sum + 32'(w.data[8*i +: 8]);
            end
        end
        return sum;
    endfunction

    // Outputs are settled and inputs may change here
    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic wait_idle();
        while (txe_n) next_cycle();
    endtask

    task automatic send_command(input int ch, input logic [3:0] code);
        next_cycle();
        wr_n        = 1'b0;
        bus_in.data = {24'h0, 8'(ch)};
        bus_in.be   = code;
    endtask

    task automatic read_packet(input int ch, input int n);
        int        got;
        bus_word_t exp;
        got = 0;
        send_command(ch, CMD_READ);
        while (1) begin
            next_cycle();
            if (!rxf_n && got < n) begin
                exp.data = {8'(ch), next_seq[ch]};
                exp.be   = 4'hF;
                check_value("read data", 64'(exp), 64'(bus_out));
                check_value("read lanes", 64'h1F, 64'({lane_oe, be_oe}));
                next_seq[ch] = next_seq[ch] + 1'b1;
                got++;
            end else if (!rxf_n) begin
                assert (n < PKT_WORDS) else
                    fail_run("rxf_n stayed low after the last word of a packet");
                wr_n = 1'b1;                    // Early release
            end else if (got > 0) begin
                break;
            end
        end
        wr_n = 1'b1;
        wait_idle();
    endtask

    task automatic write_words(input int ch, input int n);
        int        got;
        bus_word_t w;
        got = 0;
        send_command(ch, CMD_WRITE);
        while (1) begin
            next_cycle();
            if (!rxf_n && got < n) begin
                w.data = $random(seed);
                w.be   = 4'($random(seed));
                bus_in = w;                     // Pushed at the next edge
                exp_report[ch].words = exp_report[ch].words + 1'b1;
                exp_report[ch].sum   = exp_report[ch].sum + masked_byte_sum(w);
                got++;
            end else if (!rxf_n) begin
                wr_n = 1'b1;
            end else if (got > 0) begin
                break;
            end
        end
        wr_n = 1'b1;
        wait_idle();
        while (sink_report[ch].words != exp_report[ch].words) next_cycle();
        for (int c = 1; c <= NUM_CH; c++) begin
            check_value("sink report", 64'(exp_report[c]), 64'(sink_report[c]));
        end
    endtask

    task automatic send_invalid(input int ch, input logic [3:0] code);
        send_command(ch, code);
        for (int i = 0; i < 8; i++) begin
            next_cycle();
            wr_n = 1'b1;
            check_value("invalid command", 64'h1, 64'({txe_n, rxf_n}));
        end
    endtask

    initial begin
        int n;
        seed   = 32'h6539;
        clk    = 1'b0;
        reset  = 1'b1;
        wr_n   = 1'b1;
        bus_in = '0;
        for (int c = 1; c <= NUM_CH; c++) begin
            next_seq[c]   = '0;
            exp_report[c] = '0;
        end
        repeat (5) @(posedge clk);
        #2;
        reset = 1'b0;
        next_cycle();
        check_value("reset outputs", 64'h9, 64'({lane_oe, txe_n, rxf_n}));
        repeat (`MCFIFO_RESET_WAIT + 2) next_cycle();
        check_value("idle status", 64'h0, 64'(bus_out));  // All ready, all space

        for (int c = 1; c <= NUM_CH; c++) begin
            read_packet(c, PKT_WORDS);
            read_packet(c, PKT_WORDS);
        end
        for (int c = 1; c <= NUM_CH; c++) begin
            write_words(c, PKT_WORDS);
        end

        n = 1 + int'({$random(seed)} % (PKT_WORDS - 1));
        write_words(2, n);
        n = 1 + int'({$random(seed)} % (PKT_WORDS - 1));
        read_packet(3, n);
        read_packet(3, PKT_WORDS);              // Continues after the early stop

        send_invalid(0, CMD_READ);
        send_invalid(NUM_CH + 1, CMD_WRITE);
        send_invalid(1, 4'd2);
        read_packet(1, PKT_WORDS);
        write_words(4, PKT_WORDS);

        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

/* common/mcfifo_defs.svh */
`ifndef MCFIFO_DEFS_SVH
`define MCFIFO_DEFS_SVH

// Channel count of at most 4 as the status nibbles are 4 bits wide
`define MCFIFO_NUM_CHANNELS 4

// Words moved per bus packet
`define MCFIFO_PACKET_WORDS 8

// Words per channel buffer, room for two packets
`define MCFIFO_BUF_DEPTH 16

// Idle cycles after reset before commands are served
`define MCFIFO_RESET_WAIT 16

`endif

/* common/mcfifo_pkg.sv */
`default_nettype none

package mcfifo_pkg;

    // One 32-bit bus word with its byte enables
    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  be;     // One bit per byte lane
    } bus_word_t;

    // Command code carried on be during the command phase
    typedef enum logic [3:0] {
        CMD_READ  = 4'd0,    // Host reads from chip
        CMD_WRITE = 4'd1     // Host writes to chip
    } bus_cmd_e;

    typedef enum logic [3:0] {
        ST_RESET,
        ST_IDLE,
        ST_READ_BTA1,
        ST_READ_BTA2,
        ST_READ_DATA,
        ST_READ_BTA3,
        ST_WRITE_BTA1,
        ST_WRITE_DATA,
        ST_WRITE_BTA2
    } engine_state_e;

    // Running totals kept by each channel sink
    typedef struct packed {
        logic [15:0] words;  // Words drained
        logic [31:0] sum;    // Sum of enabled bytes
    } sink_report_t;

endpackage

`default_nettype wire

/* compile.f */
+incdir+common
common/mcfifo_pkg.sv
source/packet_fifo.sv
source/channel_source.sv
source/channel_sink.sv
mcfifo_bus/mcfifo_bus_engine.sv
source/mcfifo_top.sv
bench/tb_mcfifo.sv

/* mcfifo_bus/mcfifo_bus_engine.sv */
`timescale 1ns/100ps
`default_nettype none
`include "mcfifo_defs.svh"

module mcfifo_bus_engine
    import mcfifo_pkg::*;
(
    input  wire                              clk,
    input  wire                              reset,
    input  wire                              wr_n,      // Host request, active low
    input  wire bus_word_t                   bus_in,
    input  wire bus_word_t                   th_head [`MCFIFO_NUM_CHANNELS:1],
    input  wire [`MCFIFO_NUM_CHANNELS:1]     th_ready,
    input  wire [`MCFIFO_NUM_CHANNELS:1]     fh_space,
    output bus_word_t                        bus_out,
    output logic [3:0]                       lane_oe,
    output logic                             be_oe,
    output logic                             txe_n,
    output logic                             rxf_n,     // Data phase acknowledge
    output logic [`MCFIFO_NUM_CHANNELS:1]    th_pop,
    output logic [`MCFIFO_NUM_CHANNELS:1]    fh_push,
    output bus_word_t                        fh_word
);

    localparam int NUM_CH    = `MCFIFO_NUM_CHANNELS;
    localparam int PKT_WORDS = `MCFIFO_PACKET_WORDS;
    localparam int CH_W      = $clog2(NUM_CH + 1);
    localparam int WC_W      = $clog2(PKT_WORDS + 1);
    localparam int RC_W      = $clog2(`MCFIFO_RESET_WAIT + 1);
    localparam logic [3:0] STATUS_LANES = 4'b0010;   // Only lane 1 on bits 15:8

    engine_state_e   state;
    logic [CH_W-1:0] ch_sel;
    logic [WC_W-1:0] word_count;
    logic [RC_W-1:0] reset_count;

    logic [7:0] cmd_channel;
    bus_cmd_e   cmd;
    logic       chan_ok;
    logic       sel_ready;
    logic       sel_space;
    logic       cmd_ok;
    logic       xfer;
    logic       last_word;
    bus_word_t  head_word;
    logic [3:0] ready_n;
    logic [3:0] space_n;

    assign cmd_channel = bus_in.data[7:0];
    assign cmd         = bus_cmd_e'(bus_in.be);

    // Look up the flags of the channel named in the command word
    always_comb begin
        chan_ok   = 1'b0;
        sel_ready = 1'b0;
        sel_space = 1'b0;
        for (int i = 1; i <= NUM_CH; i++) begin
            if (cmd_channel == 8'(i)) begin
                chan_ok   = 1'b1;
                sel_ready = th_ready[i];
                sel_space = fh_space[i];
            end
        end
    end

    assign cmd_ok = chan_ok && ((cmd == CMD_READ && sel_ready) ||
                                (cmd == CMD_WRITE && sel_space));

    assign xfer      = !wr_n && !rxf_n &&
                       (state == ST_READ_DATA || state == ST_WRITE_DATA);
    assign last_word = (word_count == WC_W'(PKT_WORDS - 1));

    // Pop and push go to the selected channel only
    always_comb begin
        head_word = '0;
        th_pop    = '0;
        fh_push   = '0;
        for (int i = 1; i <= NUM_CH; i++) begin
            if (ch_sel == CH_W'(i)) begin
                head_word  = th_head[i];
                th_pop[i]  = xfer && (state == ST_READ_DATA);
                fh_push[i] = xfer && (state == ST_WRITE_DATA);
            end
        end
    end

    assign fh_word = bus_in;

    // Unused channels report busy and full
    always_comb begin
        ready_n = 4'hF;
        space_n = 4'hF;
        for (int i = 1; i <= NUM_CH; i++) begin
            ready_n[i-1] = ~th_ready[i];
            space_n[i-1] = ~fh_space[i];
        end
    end

    always_comb begin
        if (state == ST_READ_DATA) begin
            bus_out = head_word;
        end else begin
            bus_out              = '0;
            bus_out.data[15:12]  = ready_n;
            bus_out.data[11:8]   = space_n;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= ST_RESET;
            ch_sel      <= '0;
            word_count  <= '0;
            reset_count <= '0;
            txe_n       <= 1'b0;
            rxf_n       <= 1'b1;
            lane_oe     <= STATUS_LANES;
            be_oe       <= 1'b0;
        end else begin
            case (state)
                ST_RESET: begin
                    if (reset_count == RC_W'(`MCFIFO_RESET_WAIT - 1)) begin
                        state <= ST_IDLE;
                    end else begin
                        reset_count <= reset_count + 1'b1;
                    end
                end
                ST_IDLE: begin
                    if (!wr_n && cmd_ok) begin
                        ch_sel <= cmd_channel[CH_W-1:0];
                        txe_n  <= 1'b1;              // Status no longer valid
                        state  <= (cmd == CMD_READ) ? ST_READ_BTA1 : ST_WRITE_BTA1;
                    end
                end
                ST_READ_BTA1: begin
                    lane_oe    <= 4'hF;              // Chip takes the whole bus
                    be_oe      <= 1'b1;
                    word_count <= '0;
                    state      <= ST_READ_BTA2;
                end
                ST_READ_BTA2: begin
                    rxf_n <= 1'b0;
                    state <= ST_READ_DATA;
                end
                ST_READ_DATA: begin
                    if (xfer) begin
                        word_count <= word_count + 1'b1;
                    end
                    if ((xfer && last_word) || wr_n) begin
                        rxf_n <= 1'b1;
                        state <= ST_READ_BTA3;
                    end
                end
                ST_READ_BTA3: begin
                    lane_oe <= STATUS_LANES;
                    be_oe   <= 1'b0;
                    txe_n   <= 1'b0;
                    state   <= ST_IDLE;
                end
                ST_WRITE_BTA1: begin
                    lane_oe    <= 4'h0;              // Host drives data
                    rxf_n      <= 1'b0;
                    word_count <= '0;
                    state      <= ST_WRITE_DATA;
                end
                ST_WRITE_DATA: begin
                    if (xfer) begin
                        word_count <= word_count + 1'b1;
                    end
                    if ((xfer && last_word) || wr_n) begin
                        rxf_n <= 1'b1;
                        state <= ST_WRITE_BTA2;
                    end
                end
                ST_WRITE_BTA2: begin
                    lane_oe <= STATUS_LANES;
                    txe_n   <= 1'b0;
                    state   <= ST_IDLE;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* source/channel_sink.sv */
`timescale 1ns/100ps
`default_nettype none

module channel_sink
    import mcfifo_pkg::*;
(
    input  wire            clk,
    input  wire            reset,
    input  wire            empty,
    input  wire bus_word_t word,
    output logic           pop,
    output sink_report_t   report
);

    logic [31:0] lane_sum;

    // Drain as soon as anything arrives
    assign pop = !empty;

    // Add up the bytes whose enable is set
    always_comb begin
        lane_sum = '0;
        for (int i = 0; i < 4; i++) begin
            if (word.be[i]) begin
                lane_sum = lane_sum + 32'(word.data[8*i +: 8]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            report <= '0;
        end else if (pop) begin
            report.words <= report.words + 1'b1;
            report.sum   <= report.sum + lane_sum;   // Wraps at 32 bits
        end
    end

endmodule

`default_nettype wire

/* source/channel_source.sv */
`timescale 1ns/100ps
`default_nettype none

module channel_source
    import mcfifo_pkg::*;
#(
    parameter int CHANNEL = 1
)
(
    input  wire       clk,
    input  wire       reset,
    input  wire       full,
    output logic      push,
    output bus_word_t word
);

    logic [23:0] seq;    // Words pushed so far

    // Fill whenever the buffer has room
    assign push = !full;

    always_comb begin
        word.data = {8'(CHANNEL), seq};   // Channel tag over sequence
        word.be   = 4'hF;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            seq <= '0;
        end else if (push) begin
            seq <= seq + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* source/mcfifo_top.sv */
`timescale 1ns/100ps
`default_nettype none
`include "mcfifo_defs.svh"

module mcfifo_top
    import mcfifo_pkg::*;
(
    input  wire            clk,
    input  wire            reset,
    input  wire            wr_n,
    input  wire bus_word_t bus_in,
    output bus_word_t      bus_out,
    output logic [3:0]     lane_oe,
    output logic           be_oe,
    output logic           txe_n,
    output logic           rxf_n,
    output sink_report_t   sink_report [`MCFIFO_NUM_CHANNELS:1]
);

    localparam int NUM_CH = `MCFIFO_NUM_CHANNELS;

    // To-host path from source through buffer to engine
    bus_word_t          th_word [NUM_CH:1];
    bus_word_t          th_head [NUM_CH:1];
    logic [NUM_CH:1]    th_push;
    logic [NUM_CH:1]    th_full;
    logic [NUM_CH:1]    th_ready;
    logic [NUM_CH:1]    th_pop;

    // From-host path from engine through buffer to sink
    bus_word_t          fh_word;
    bus_word_t          fh_head [NUM_CH:1];
    logic [NUM_CH:1]    fh_push;
    logic [NUM_CH:1]    fh_space;
    logic [NUM_CH:1]    fh_empty;
    logic [NUM_CH:1]    fh_pop;

    mcfifo_bus_engine i_bus_engine (
        .clk      (clk),
        .reset    (reset),
        .wr_n     (wr_n),
        .bus_in   (bus_in),
        .th_head  (th_head),
        .th_ready (th_ready),
        .fh_space (fh_space),
        .bus_out  (bus_out),
        .lane_oe  (lane_oe),
        .be_oe    (be_oe),
        .txe_n    (txe_n),
        .rxf_n    (rxf_n),
        .th_pop   (th_pop),
        .fh_push  (fh_push),
        .fh_word  (fh_word)
    );

    for (genvar ch = 1; ch <= NUM_CH; ch++) begin : g_channel
        channel_source #(.CHANNEL(ch)) i_source (
            .clk   (clk),
            .reset (reset),
            .full  (th_full[ch]),
            .push  (th_push[ch]),
            .word  (th_word[ch])
        );

        packet_fifo #(.DEPTH(`MCFIFO_BUF_DEPTH)) i_th_fifo (
            .clk          (clk),
            .reset        (reset),
            .push         (th_push[ch]),
            .wr_word      (th_word[ch]),
            .pop          (th_pop[ch]),
            .rd_word      (th_head[ch]),
            .empty        (),
            .full         (th_full[ch]),
            .packet_ready (th_ready[ch]),
            .packet_space ()
        );

        packet_fifo #(.DEPTH(`MCFIFO_BUF_DEPTH)) i_fh_fifo (
            .clk          (clk),
            .reset        (reset),
            .push         (fh_push[ch]),
            .wr_word      (fh_word),
            .pop          (fh_pop[ch]),
            .rd_word      (fh_head[ch]),
            .empty        (fh_empty[ch]),
            .full         (),
            .packet_ready (),
            .packet_space (fh_space[ch])
        );

        channel_sink i_sink (
            .clk    (clk),
            .reset  (reset),
            .empty  (fh_empty[ch]),
            .word   (fh_head[ch]),
            .pop    (fh_pop[ch]),
            .report (sink_report[ch])
        );
    end

endmodule

`default_nettype wire

/* source/packet_fifo.sv */
`timescale 1ns/100ps
`default_nettype none
`include "mcfifo_defs.svh"

module packet_fifo
    import mcfifo_pkg::*;
#(
    parameter int DEPTH = `MCFIFO_BUF_DEPTH
)
(
    input  wire            clk,
    input  wire            reset,
    input  wire            push,
    input  wire bus_word_t wr_word,
    input  wire            pop,
    output bus_word_t      rd_word,          // Show-ahead head
    output logic           empty,
    output logic           full,
    output logic           packet_ready,     // A whole packet stored
    output logic           packet_space      // Room for a whole packet
);

    localparam int AW        = $clog2(DEPTH);
    localparam int CW        = $clog2(DEPTH + 1);
    localparam int PKT_WORDS = `MCFIFO_PACKET_WORDS;

    bus_word_t     mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          do_push;
    logic          do_pop;

    function automatic logic [AW-1:0] ptr_next(input logic [AW-1:0] ptr);
        return (ptr == AW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= wr_word;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;     // Both or neither
            endcase
        end
    end

    assign rd_word      = mem[rd_ptr];
    assign empty        = (count == '0);
    assign full         = (count == CW'(DEPTH));
    assign packet_ready = (count >= CW'(PKT_WORDS));
    assign packet_space = ((CW'(DEPTH) - count) >= CW'(PKT_WORDS));

endmodule

`default_nettype wire
